/* design/wfifo_pkg.sv */
package wfifo_pkg;

   // write side is one byte, read side is one 32-bit word
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;

   // number of byte lanes in a read word
   localparam int N_LANES = R_DATA_W / W_DATA_W;

   // fifo depth in write words (bytes)
   localparam int ADDR_W = 6;

   // low write pointer bits pick the bank
   localparam int LANE_SEL_W = $clog2(N_LANES);

   // each bank holds one byte of every stored word
   localparam int BANK_ADDR_W = ADDR_W - LANE_SEL_W;

   // read pointer counts whole words
   localparam int R_ADDR_W = BANK_ADDR_W;

   // level needs one extra bit to reach the full count
   localparam int LEVEL_W = ADDR_W + 1;

   // capacity in bytes
   localparam logic [LEVEL_W-1:0] FIFO_SIZE = LEVEL_W'(1 << ADDR_W);

   // level steps per accepted operation
   localparam logic [LEVEL_W-1:0] W_INCR = LEVEL_W'(1);
   localparam logic [LEVEL_W-1:0] R_INCR = LEVEL_W'(N_LANES);

   // wide read word split into its byte lanes, lane 0 in the low bits
   typedef logic [N_LANES-1:0][W_DATA_W-1:0] lane_t;

endpackage

/* design/wfifo_ram_bank.sv */
`timescale 1ns/1ps

module wfifo_ram_bank (
   input  logic                              clk_i,
   input  logic                              w_en_i,
   input  logic [wfifo_pkg::BANK_ADDR_W-1:0] w_addr_i,
   input  logic [wfifo_pkg::W_DATA_W-1:0]    w_data_i,
   input  logic                              r_en_i,
   input  logic [wfifo_pkg::BANK_ADDR_W-1:0] r_addr_i,
   output logic [wfifo_pkg::W_DATA_W-1:0]    r_data_o
);

   import wfifo_pkg::*;

   logic [W_DATA_W-1:0] mem [2**BANK_ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read register only loads on a read, otherwise holds
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* design/wfifo_ram_asym.sv */
`timescale 1ns/1ps

module wfifo_ram_asym (
   input  logic                              clk_i,

   // narrow write from the fifo control
   input  logic                              w_en_i,
   input  logic [wfifo_pkg::ADDR_W-1:0]      w_addr_i,
   input  logic [wfifo_pkg::W_DATA_W-1:0]    w_data_i,

   // wide read
   input  logic                              r_en_i,
   input  logic [wfifo_pkg::R_ADDR_W-1:0]    r_addr_i,
   output logic [wfifo_pkg::R_DATA_W-1:0]    r_data_o,

   // per-bank memory port
   output logic [wfifo_pkg::N_LANES-1:0]     mem_w_en_o,
   output logic [wfifo_pkg::BANK_ADDR_W-1:0] mem_w_addr_o,
   output logic [wfifo_pkg::W_DATA_W-1:0]    mem_w_data_o,
   output logic                              mem_r_en_o,
   output logic [wfifo_pkg::BANK_ADDR_W-1:0] mem_r_addr_o,
   input  wfifo_pkg::lane_t                  mem_r_data_i
);

   import wfifo_pkg::*;

   logic [LANE_SEL_W-1:0] w_lane;
   logic [R_DATA_W-1:0]   rd_word;

   // low address bits select the bank, upper bits index into it
   assign w_lane       = w_addr_i[LANE_SEL_W-1:0];
   assign mem_w_addr_o = w_addr_i[ADDR_W-1:LANE_SEL_W];
   assign mem_w_data_o = w_data_i;

   // one-hot bank write enable
   always_comb begin
      mem_w_en_o = '0;
      if (w_en_i) begin
         mem_w_en_o[w_lane] = 1'b1;
      end
   end

   // all banks read the same word address
   assign mem_r_en_o   = r_en_i;
   assign mem_r_addr_o = r_addr_i;

   // lane i goes to byte i of the wide word
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < N_LANES; i++) begin
         rd_word[i*W_DATA_W +: W_DATA_W] = mem_r_data_i[i];
      end
   end

   // bank read registers hold the word between reads
   assign r_data_o = rd_word;

endmodule

/* design/wfifo_sync.sv */
`timescale 1ns/1ps

module wfifo_sync (
   input  logic                              clk_i,
   input  logic                              rst_i,

   // write side
   input  logic                              w_en_i,
   input  logic [wfifo_pkg::W_DATA_W-1:0]    w_data_i,
   output logic                              w_full_o,

   // read side
   input  logic                              r_en_i,
   output logic [wfifo_pkg::R_DATA_W-1:0]    r_data_o,
   output logic                              r_empty_o,

   // fill level in bytes
   output logic [wfifo_pkg::LEVEL_W-1:0]     level_o,

   // memory port towards the banks
   output logic [wfifo_pkg::N_LANES-1:0]     mem_w_en_o,
   output logic [wfifo_pkg::BANK_ADDR_W-1:0] mem_w_addr_o,
   output logic [wfifo_pkg::W_DATA_W-1:0]    mem_w_data_o,
   output logic                              mem_r_en_o,
   output logic [wfifo_pkg::BANK_ADDR_W-1:0] mem_r_addr_o,
   input  wfifo_pkg::lane_t                  mem_r_data_i
);

   import wfifo_pkg::*;

   logic                w_en_acc;
   logic                r_en_acc;
   logic [ADDR_W-1:0]   w_ptr;
   logic [R_ADDR_W-1:0] r_ptr;
   logic [LEVEL_W-1:0]  level_q;
   logic [LEVEL_W-1:0]  level_nxt;
   logic                r_empty_nxt;
   logic                w_full_nxt;

   // requests qualified by the registered flags
   assign w_en_acc = w_en_i & ~w_full_o;
   assign r_en_acc = r_en_i & ~r_empty_o;

   // byte write pointer, wraps at the fifo size
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr <= '0;
      end else if (w_en_acc) begin
         w_ptr <= w_ptr + 1'b1;
      end
   end

   // word read pointer
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r_ptr <= '0;
      end else if (r_en_acc) begin
         r_ptr <= r_ptr + 1'b1;
      end
   end

   // next level, both steps apply on the same edge
   always_comb begin
      level_nxt = level_q;
      if (w_en_acc && !r_en_acc) begin
         level_nxt = level_q + W_INCR;
      end else if (w_en_acc && r_en_acc) begin
         level_nxt = level_q + W_INCR - R_INCR;
      end else if (r_en_acc) begin
         level_nxt = level_q - R_INCR;
      end
   end

   // empty means less than one whole word stored
   assign r_empty_nxt = level_nxt < R_INCR;
   assign w_full_nxt  = level_nxt > (FIFO_SIZE - W_INCR);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= r_empty_nxt;
         w_full_o  <= w_full_nxt;
      end
   end

   assign level_o = level_q;

   // narrow-write, wide-read memory adapter
   wfifo_ram_asym u_ram_asym (
      .clk_i        (clk_i),
      .w_en_i       (w_en_acc),
      .w_addr_i     (w_ptr),
      .w_data_i     (w_data_i),
      .r_en_i       (r_en_acc),
      .r_addr_i     (r_ptr),
      .r_data_o     (r_data_o),
      .mem_w_en_o   (mem_w_en_o),
      .mem_w_addr_o (mem_w_addr_o),
      .mem_w_data_o (mem_w_data_o),
      .mem_r_en_o   (mem_r_en_o),
      .mem_r_addr_o (mem_r_addr_o),
      .mem_r_data_i (mem_r_data_i)
   );

endmodule

/* design/wfifo_top.sv */
`timescale 1ns/1ps

module wfifo_top (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          w_en_i,
   input  logic [wfifo_pkg::W_DATA_W-1:0] w_data_i,
   output logic                          w_full_o,
   input  logic                          r_en_i,
   output logic [wfifo_pkg::R_DATA_W-1:0] r_data_o,
   output logic                          r_empty_o,
   output logic [wfifo_pkg::LEVEL_W-1:0]  level_o
);

   import wfifo_pkg::*;

   logic [N_LANES-1:0]     mem_w_en;
   logic [BANK_ADDR_W-1:0] mem_w_addr;
   logic [W_DATA_W-1:0]    mem_w_data;
   logic                   mem_r_en;
   logic [BANK_ADDR_W-1:0] mem_r_addr;
   lane_t                  mem_r_data;

   wfifo_sync u_fifo (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .w_en_i       (w_en_i),
      .w_data_i     (w_data_i),
      .w_full_o     (w_full_o),
      .r_en_i       (r_en_i),
      .r_data_o     (r_data_o),
      .r_empty_o    (r_empty_o),
      .level_o      (level_o),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .mem_r_data_i (mem_r_data)
   );

   // one byte-wide bank per lane, write enable is per bank
   for (genvar i = 0; i < N_LANES; i++) begin : g_bank
      wfifo_ram_bank u_bank (
         .clk_i    (clk_i),
         .w_en_i   (mem_w_en[i]),
         .w_addr_i (mem_w_addr),
         .w_data_i (mem_w_data),
         .r_en_i   (mem_r_en),
         .r_addr_i (mem_r_addr),
         .r_data_o (mem_r_data[i])
      );
   end

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_o
);

   localparam int PERIOD_NS = 100;

   // free running, first rising edge at half a period
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

/* verif/tb_wfifo_checker.sv */
`timescale 1ns/1ps

module tb_wfifo_checker (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           w_en_i,
   input  logic [wfifo_pkg::W_DATA_W-1:0] w_data_i,
   input  logic                           w_full_i,
   input  logic                           r_en_i,
   input  logic [wfifo_pkg::R_DATA_W-1:0] r_data_i,
   input  logic                           r_empty_i,
   input  logic [wfifo_pkg::LEVEL_W-1:0]  level_i,
   output int                             mismatch_cnt_o,
   output int                             read_cnt_o,
   output int                             both_cnt_o
);

   import wfifo_pkg::*;

   localparam int CAPACITY   = 64;
   localparam int WORD_BYTES = 4;

   logic [W_DATA_W-1:0] byte_q [$];
   logic [R_DATA_W-1:0] exp_word;
   logic                word_valid;
   logic                w_acc;
   logic                r_acc;
   int                  mismatches;
   int                  reads;
   int                  both_edges;

   assign mismatch_cnt_o = mismatches;
   assign read_cnt_o     = reads;
   assign both_cnt_o     = both_edges;

   initial begin
      mismatches = 0;
      reads      = 0;
      both_edges = 0;
      word_valid = 1'b0;
      exp_word   = '0;
   end

   // oldest byte ends up in the low bits
   function automatic logic [R_DATA_W-1:0] expected_word(
      input logic [W_DATA_W-1:0] b0,
      input logic [W_DATA_W-1:0] b1,
      input logic [W_DATA_W-1:0] b2,
      input logic [W_DATA_W-1:0] b3
   );
      return {b3, b2, b1, b0};
   endfunction

   task automatic report_mismatch(
      input string               name,
      input logic [R_DATA_W-1:0] exp_v,
      input logic [R_DATA_W-1:0] act_v
   );
      $display("mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
      mismatches++;
   endtask

   // outputs still show the state from before this edge
   task automatic check_flags();
      int count;
      logic exp_empty;
      logic exp_full;
      count     = byte_q.size();
      exp_empty = count < WORD_BYTES;
      exp_full  = count > CAPACITY - 1;
      if (level_i !== LEVEL_W'(count)) begin
         report_mismatch("level_o", R_DATA_W'(count), R_DATA_W'(level_i));
      end
      if (r_empty_i !== exp_empty) begin
         report_mismatch("r_empty_o", R_DATA_W'(exp_empty), R_DATA_W'(r_empty_i));
      end
      if (w_full_i !== exp_full) begin
         report_mismatch("w_full_o", R_DATA_W'(exp_full), R_DATA_W'(w_full_i));
      end
   endtask

   always @(posedge clk_i) begin
      if (rst_i) begin
         byte_q.delete();
         word_valid = 1'b0;
      end else begin
         check_flags();

         // last read word must hold until the next accepted read
         if (word_valid && r_data_i !== exp_word) begin
            report_mismatch("r_data_o", exp_word, r_data_i);
         end

         w_acc = w_en_i && (byte_q.size() < CAPACITY);
         r_acc = r_en_i && (byte_q.size() >= WORD_BYTES);

         if (r_acc) begin
            exp_word = expected_word(byte_q[0], byte_q[1], byte_q[2], byte_q[3]);
            for (int i = 0; i < WORD_BYTES; i++) begin
               void'(byte_q.pop_front());
            end
            word_valid = 1'b1;
            reads++;
         end

         if (w_acc) begin
            byte_q.push_back(w_data_i);
         end

         if (w_acc && r_acc) begin
            both_edges++;
         end
      end
   end

endmodule

/* verif/tb_wfifo.sv */
`timescale 1ns/1ps

module tb_wfifo;

   import wfifo_pkg::*;

   localparam int RST_CYCLES  = 10;
   localparam int WAIT_LIMIT  = 200;
   localparam int PACK_WORDS  = 8;
   localparam int DRIVE_DLY   = 1;

   logic                clk;
   logic                rst;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                w_full;
   logic                r_en;
   logic [R_DATA_W-1:0] r_data;
   logic                r_empty;
   logic [LEVEL_W-1:0]  level;
   int                  mismatches;
   int                  reads_checked;
   int                  both_edges;
   int                  timeouts;

   tb_clkgen u_clkgen (
      .clk_o (clk)
   );

   wfifo_top u_wfifo_top (
      .clk_i     (clk),
      .rst_i     (rst),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_full_o  (w_full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .level_o   (level)
   );

   tb_wfifo_checker u_checker (
      .clk_i          (clk),
      .rst_i          (rst),
      .w_en_i         (w_en),
      .w_data_i       (w_data),
      .w_full_i       (w_full),
      .r_en_i         (r_en),
      .r_data_i       (r_data),
      .r_empty_i      (r_empty),
      .level_i        (level),
      .mismatch_cnt_o (mismatches),
      .read_cnt_o     (reads_checked),
      .both_cnt_o     (both_edges)
   );

   // drive point just after the next rising edge
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         next_cycle();
      end
   endtask

   task automatic push_byte(input logic [W_DATA_W-1:0] data);
      int n;
      n = 0;
      while (w_full && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (w_full) begin
         $display("error: w_full_o stayed high for %0d cycles at %0t ns", WAIT_LIMIT, $time);
         timeouts++;
      end
      w_en   = 1'b1;
      w_data = data;
      next_cycle();
      w_en = 1'b0;
   endtask

   task automatic pop_word();
      int n;
      n = 0;
      while (r_empty && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (r_empty) begin
         $display("error: r_empty_o stayed high for %0d cycles at %0t ns", WAIT_LIMIT, $time);
         timeouts++;
      end
      r_en = 1'b1;
      next_cycle();
      r_en = 1'b0;
   endtask

   // keep writing until full, then a few writes that must be dropped
   task automatic fill_until_full(input int extra);
      int n;
      n = 0;
      w_en = 1'b1;
      while (!w_full && n < WAIT_LIMIT) begin
         w_data = W_DATA_W'($urandom);
         next_cycle();
         n++;
      end
      if (!w_full) begin
         $display("error: fifo never reported full within %0d cycles", WAIT_LIMIT);
         timeouts++;
      end
      for (int i = 0; i < extra; i++) begin
         w_data = W_DATA_W'($urandom);
         next_cycle();
      end
      w_en = 1'b0;
   endtask

   task automatic drain_until_empty(input int extra);
      int n;
      n = 0;
      r_en = 1'b1;
      while (!r_empty && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!r_empty) begin
         $display("error: fifo never reported empty within %0d cycles", WAIT_LIMIT);
         timeouts++;
      end
      idle_cycles(extra);
      r_en = 1'b0;
   endtask

   task automatic random_traffic(input int cycles, input int w_pct, input int r_pct);
      for (int i = 0; i < cycles; i++) begin
         w_en   = ($urandom % 100) < w_pct;
         w_data = W_DATA_W'($urandom);
         r_en   = ($urandom % 100) < r_pct;
         next_cycle();
      end
      w_en = 1'b0;
      r_en = 1'b0;
   endtask

   initial begin
      rst      = 1'b1;
      w_en     = 1'b0;
      w_data   = '0;
      r_en     = 1'b0;
      timeouts = 0;
      void'($urandom(32'h4324));

      repeat (RST_CYCLES) begin
         @(posedge clk);
      end
      #DRIVE_DLY;
      rst = 1'b0;
      idle_cycles(2);

      // whole words in, then read back with idle gaps for the hold check
      for (int i = 0; i < N_LANES * PACK_WORDS; i++) begin
         push_byte(W_DATA_W'($urandom));
      end
      for (int i = 0; i < PACK_WORDS; i++) begin
         pop_word();
         idle_cycles(int'($urandom % 4));
      end

      // reads against a partial word are ignored
      for (int i = 0; i < N_LANES - 1; i++) begin
         push_byte(W_DATA_W'($urandom));
      end
      r_en = 1'b1;
      idle_cycles(5);
      r_en = 1'b0;
      push_byte(W_DATA_W'($urandom));
      pop_word();
      idle_cycles(2);

      fill_until_full(5);
      drain_until_empty(5);

      // balanced, write heavy, read heavy
      random_traffic(700, 60, 15);
      random_traffic(600, 90, 10);
      random_traffic(700, 40, 30);
      drain_until_empty(2);
      idle_cycles(3);

      if (reads_checked == 0) begin
         $display("error: no read word was compared");
      end
      if (both_edges == 0) begin
         $display("error: no edge accepted a read and a write together");
      end
      $display("summary: %0d mismatches, %0d timeouts, %0d words compared, %0d edges with both",
               mismatches, timeouts, reads_checked, both_edges);
      if (mismatches == 0 && timeouts == 0 && reads_checked > 0 && both_edges > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* wfifo.f */
design/wfifo_pkg.sv
design/wfifo_ram_bank.sv
design/wfifo_ram_asym.sv
design/wfifo_sync.sv
design/wfifo_top.sv
verif/tb_clkgen.sv
verif/tb_wfifo_checker.sv
verif/tb_wfifo.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_wfifo
FILELIST  = wfifo.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard design/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulator exits cleanly and prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; \
	echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
